// File: source/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // two views of the same instruction word
    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_s;

    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;      // jump index is {rs, rt, imm}
    } iType_s;

    typedef union packed {
        rType_s r;
        iType_s i;
    } instr_u;

    typedef enum logic [3:0] {
        aluAddu, aluSubu, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluLui
    } aluOp_e;

    typedef enum logic [2:0] {
        memNone, memLw, memLb, memLbu, memSw, memSb
    } memOp_e;

    typedef enum logic [1:0] {
        brNone, brBeq, brBne, brJr
    } branch_e;

    typedef struct packed {
        aluOp_e  aluOp;
        logic    useImm;   // b operand from imm instead of rt
        logic    regWrite;
        memOp_e  memOp;
        branch_e branch;
        logic    link;     // result is pc+8
    } ctrl_s;

    typedef struct packed {
        word_t      pc;
        word_t      rsVal;
        word_t      rtVal;
        regAddr_t   rsAddr;
        regAddr_t   rtAddr;
        word_t      imm;
        logic [4:0] shamt;
        regAddr_t   dest;
        ctrl_s      ctrl;
    } decToExe_s;

    typedef struct packed {
        word_t    pc;
        word_t    aluOut;
        word_t    storeData;
        regAddr_t dest;
        ctrl_s    ctrl;
    } exeToMem_s;

    typedef struct packed {
        logic     wen;
        regAddr_t wnum;
        word_t    wdata;
    } wbPort_s;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSw      = 6'h2b;

    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage

// File: source/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic               clk,
    input  logic               rstN_i,
    input  mipsPkg::regAddr_t  rsAddr_i,
    input  mipsPkg::regAddr_t  rtAddr_i,
    input  mipsPkg::wbPort_s   wb_i,
    input  logic               hold_i,
    output mipsPkg::word_t     rsVal_o,
    output mipsPkg::word_t     rtVal_o
);

    mipsPkg::word_t regs [32];
    logic           doWrite;

    assign doWrite = wb_i.wen && !hold_i && (wb_i.wnum != '0);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (doWrite) begin
            regs[wb_i.wnum] <= wb_i.wdata;
        end
    end

    // write-through so D sees the value M writes this cycle
    assign rsVal_o = (rsAddr_i == '0) ? '0 :
                     (doWrite && wb_i.wnum == rsAddr_i) ? wb_i.wdata : regs[rsAddr_i];
    assign rtVal_o = (rtAddr_i == '0) ? '0 :
                     (doWrite && wb_i.wnum == rtAddr_i) ? wb_i.wdata : regs[rtAddr_i];

endmodule

// File: source/instrDecode.sv
`timescale 1ns/10ps

module instrDecode (
    input  logic                clk,
    input  logic                rstN_i,
    input  mipsPkg::instr_u     instr_i,
    input  mipsPkg::word_t      pc_i,
    input  mipsPkg::word_t      rsVal_i,
    input  mipsPkg::word_t      rtVal_i,
    input  logic                hold_i,
    input  logic                bubble_i,
    output mipsPkg::regAddr_t   rsAddr_o,
    output mipsPkg::regAddr_t   rtAddr_o,
    output logic                jump_o,
    output mipsPkg::word_t      jumpPc_o,
    output mipsPkg::decToExe_s  dec_o
);

    mipsPkg::ctrl_s    ctrl;
    mipsPkg::regAddr_t dest;
    logic              zeroExt;  // andi, ori
    mipsPkg::word_t    imm;
    mipsPkg::word_t    pcPlus4;

    assign rsAddr_o = instr_i.r.rs;
    assign rtAddr_o = instr_i.r.rt;

    always_comb begin
        ctrl    = '0;  // unknown opcodes fall out as no-ops
        zeroExt = 1'b0;
        dest    = instr_i.i.rt;
        case (instr_i.r.opcode)
            mipsPkg::opSpecial: begin
                dest          = instr_i.r.rd;
                ctrl.regWrite = 1'b1;
                case (instr_i.r.funct)
                    mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAddu;
                    mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSubu;
                    mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSll:  ctrl.aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  ctrl.aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.branch   = mipsPkg::brJr;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            mipsPkg::opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.link     = 1'b1;
                dest          = 5'd31;
            end
            mipsPkg::opBeq: ctrl.branch = mipsPkg::brBeq;
            mipsPkg::opBne: ctrl.branch = mipsPkg::brBne;
            mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opAndi,
            mipsPkg::opOri, mipsPkg::opLui: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                zeroExt       = (instr_i.r.opcode == mipsPkg::opAndi) ||
                                (instr_i.r.opcode == mipsPkg::opOri);
                case (instr_i.r.opcode)
                    mipsPkg::opSlti: ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::opAndi: ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri:  ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::opLui:  ctrl.aluOp = mipsPkg::aluLui;
                    default:         ctrl.aluOp = mipsPkg::aluAddu;
                endcase
            end
            mipsPkg::opLw, mipsPkg::opLb, mipsPkg::opLbu: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memOp    = (instr_i.r.opcode == mipsPkg::opLw) ? mipsPkg::memLw :
                                (instr_i.r.opcode == mipsPkg::opLb) ? mipsPkg::memLb :
                                                                      mipsPkg::memLbu;
            end
            mipsPkg::opSw, mipsPkg::opSb: begin
                ctrl.useImm = 1'b1;
                ctrl.memOp  = (instr_i.r.opcode == mipsPkg::opSw) ? mipsPkg::memSw :
                                                                    mipsPkg::memSb;
            end
            default: ;
        endcase
    end

    assign imm = zeroExt ? {16'h0, instr_i.i.imm} : {{16{instr_i.i.imm[15]}}, instr_i.i.imm};

    // j/jal leave from D, the word in F is the delay slot
    assign pcPlus4  = pc_i + 32'd4;
    assign jump_o   = (instr_i.r.opcode == mipsPkg::opJ) || (instr_i.r.opcode == mipsPkg::opJal);
    assign jumpPc_o = {pcPlus4[31:28], instr_i.i.rs, instr_i.i.rt, instr_i.i.imm, 2'b00};

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            dec_o <= '0;
        end else if (!hold_i) begin
            if (bubble_i) begin
                dec_o <= '0;  // load-use bubble
            end else begin
                dec_o <= '{pc: pc_i, rsVal: rsVal_i, rtVal: rtVal_i,
                           rsAddr: instr_i.r.rs, rtAddr: instr_i.r.rt, imm: imm,
                           shamt: instr_i.r.shamt, dest: dest, ctrl: ctrl};
            end
        end
    end

endmodule

// File: source/aluExecute.sv
`timescale 1ns/10ps

module aluExecute (
    input  logic                clk,
    input  logic                rstN_i,
    input  mipsPkg::decToExe_s  dec_i,
    input  mipsPkg::wbPort_s    wb_i,
    input  logic                hold_i,
    output logic                redirect_o,
    output mipsPkg::word_t      redirectPc_o,
    output mipsPkg::exeToMem_s  exe_o
);

    mipsPkg::word_t rsFwd;
    mipsPkg::word_t rtFwd;
    mipsPkg::word_t opB;
    mipsPkg::word_t aluRes;
    mipsPkg::word_t result;
    logic           isEqual;

    // bypass from the instruction now in M
    assign rsFwd = (wb_i.wen && wb_i.wnum == dec_i.rsAddr) ? wb_i.wdata : dec_i.rsVal;
    assign rtFwd = (wb_i.wen && wb_i.wnum == dec_i.rtAddr) ? wb_i.wdata : dec_i.rtVal;
    assign opB   = dec_i.ctrl.useImm ? dec_i.imm : rtFwd;

    always_comb begin
        case (dec_i.ctrl.aluOp)
            mipsPkg::aluSubu: aluRes = rsFwd - opB;
            mipsPkg::aluAnd:  aluRes = rsFwd & opB;
            mipsPkg::aluOr:   aluRes = rsFwd | opB;
            mipsPkg::aluXor:  aluRes = rsFwd ^ opB;
            mipsPkg::aluSlt:  aluRes = {31'h0, $signed(rsFwd) < $signed(opB)};
            mipsPkg::aluSll:  aluRes = opB << dec_i.shamt;
            mipsPkg::aluSrl:  aluRes = opB >> dec_i.shamt;
            mipsPkg::aluLui:  aluRes = {opB[15:0], 16'h0};
            default:          aluRes = rsFwd + opB;  // addu, addiu, address calc
        endcase
    end

    assign result = dec_i.ctrl.link ? dec_i.pc + 32'd8 : aluRes;

    // branches resolve here, no prediction
    assign isEqual    = (rsFwd == rtFwd);
    assign redirect_o = (dec_i.ctrl.branch == mipsPkg::brBeq &&  isEqual) ||
                        (dec_i.ctrl.branch == mipsPkg::brBne && !isEqual) ||
                        (dec_i.ctrl.branch == mipsPkg::brJr);
    assign redirectPc_o = (dec_i.ctrl.branch == mipsPkg::brJr) ? rsFwd :
                          dec_i.pc + 32'd4 + {dec_i.imm[29:0], 2'b00};

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            exe_o <= '0;
        end else if (!hold_i) begin
            exe_o <= '{pc: dec_i.pc, aluOut: result, storeData: rtFwd,
                       dest: dec_i.dest, ctrl: dec_i.ctrl};
        end
    end

endmodule

// File: source/memResult.sv
`timescale 1ns/10ps

module memResult (
    input  mipsPkg::exeToMem_s  exe_i,
    input  mipsPkg::word_t      memRdata_i,
    input  logic                hold_i,
    output logic                memEn_o,
    output mipsPkg::word_t      memAddr_o,
    output logic [3:0]          memWriteSel_o,
    output mipsPkg::word_t      memWdata_o,
    output mipsPkg::wbPort_s    wb_o
);

    logic [7:0]     loadByte;
    mipsPkg::word_t loadVal;

    assign memEn_o   = (exe_i.ctrl.memOp != mipsPkg::memNone);
    assign memAddr_o = exe_i.aluOut;

    // sb puts the byte on every lane, the enable picks one
    always_comb begin
        case (exe_i.ctrl.memOp)
            mipsPkg::memSw: memWriteSel_o = 4'b1111;
            mipsPkg::memSb: memWriteSel_o = 4'b0001 << exe_i.aluOut[1:0];
            default:        memWriteSel_o = 4'b0000;
        endcase
    end
    assign memWdata_o = (exe_i.ctrl.memOp == mipsPkg::memSb) ? {4{exe_i.storeData[7:0]}} :
                                                               exe_i.storeData;

    assign loadByte = memRdata_i[{exe_i.aluOut[1:0], 3'b000} +: 8];  // little endian

    always_comb begin
        case (exe_i.ctrl.memOp)
            mipsPkg::memLw:  loadVal = memRdata_i;
            mipsPkg::memLb:  loadVal = {{24{loadByte[7]}}, loadByte};
            mipsPkg::memLbu: loadVal = {24'h0, loadByte};
            default:         loadVal = exe_i.aluOut;
        endcase
    end

    // writes to r0 never show up
    assign wb_o.wen   = exe_i.ctrl.regWrite && (exe_i.dest != '0) && !hold_i;
    assign wb_o.wnum  = exe_i.dest;
    assign wb_o.wdata = loadVal;

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic               exeLoad_i,
    input  mipsPkg::regAddr_t  exeDest_i,
    input  mipsPkg::regAddr_t  rsAddr_i,
    input  mipsPkg::regAddr_t  rtAddr_i,
    output logic               stallFD_o,
    output logic               bubbleE_o
);

    logic destValid;
    logic srcMatch;
    logic loadUse;

    // r0 is never a real dependence
    assign destValid = exeLoad_i && (exeDest_i != '0);

    // rt is compared even for formats that don't read it
    assign srcMatch = (exeDest_i == rsAddr_i) || (exeDest_i == rtAddr_i);

    assign loadUse = destValid && srcMatch;

    // hold F and D for one cycle
    assign stallFD_o = loadUse;

    // E gets a no-op while D waits for the load data
    assign bubbleE_o = loadUse;

endmodule

// File: source/mipsCore.sv
`timescale 1ns/10ps

module mipsCore #(
    parameter mipsPkg::word_t resetPc = 32'hbfc0_0000
) (
    input  logic               clk,
    input  logic               rstN_i,
    input  mipsPkg::word_t     instr_i,
    input  mipsPkg::word_t     memRdata_i,
    input  logic               dStall_i,
    output mipsPkg::word_t     instAddr_o,
    output logic               instEn_o,
    output logic               memEn_o,
    output mipsPkg::word_t     memAddr_o,
    output logic [3:0]         memWriteSel_o,
    output mipsPkg::word_t     memWdata_o,
    output mipsPkg::word_t     dbgPc_o,
    output logic [3:0]         dbgRfWen_o,
    output mipsPkg::regAddr_t  dbgRfWnum_o,
    output mipsPkg::word_t     dbgRfWdata_o
);

    mipsPkg::word_t     pcF;
    mipsPkg::word_t     nextPc;
    mipsPkg::word_t     fdPc;
    mipsPkg::instr_u    fdInstr;
    mipsPkg::regAddr_t  rsAddrD;
    mipsPkg::regAddr_t  rtAddrD;
    mipsPkg::word_t     rsValD;
    mipsPkg::word_t     rtValD;
    logic               jumpD;
    mipsPkg::word_t     jumpPcD;
    mipsPkg::decToExe_s decE;
    mipsPkg::exeToMem_s exeM;
    mipsPkg::wbPort_s   wbM;
    logic               redirectE;
    mipsPkg::word_t     redirectPcE;
    logic               exeLoad;
    logic               stallFD;
    logic               bubbleE;
    logic               holdFD;

    assign holdFD = stallFD || dStall_i;

    // E redirect wins over a D jump
    assign nextPc = redirectE ? redirectPcE :
                    jumpD     ? jumpPcD     : pcF + 32'd4;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF <= resetPc;
        end else if (!holdFD) begin
            pcF <= nextPc;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            fdPc    <= '0;
            fdInstr <= '0;
        end else if (!holdFD) begin
            fdPc    <= pcF;
            fdInstr <= redirectE ? '0 : instr_i;  // drop the word after the delay slot
        end
    end

    assign instAddr_o = pcF;
    assign instEn_o   = 1'b1;  // fetch every cycle

    regFile uRegFile (
        .clk(clk), .rstN_i(rstN_i), .rsAddr_i(rsAddrD), .rtAddr_i(rtAddrD),
        .wb_i(wbM), .hold_i(dStall_i), .rsVal_o(rsValD), .rtVal_o(rtValD)
    );

    instrDecode uDecode (
        .clk(clk), .rstN_i(rstN_i), .instr_i(fdInstr), .pc_i(fdPc),
        .rsVal_i(rsValD), .rtVal_i(rtValD), .hold_i(dStall_i), .bubble_i(bubbleE),
        .rsAddr_o(rsAddrD), .rtAddr_o(rtAddrD), .jump_o(jumpD), .jumpPc_o(jumpPcD),
        .dec_o(decE)
    );

    aluExecute uExecute (
        .clk(clk), .rstN_i(rstN_i), .dec_i(decE), .wb_i(wbM), .hold_i(dStall_i),
        .redirect_o(redirectE), .redirectPc_o(redirectPcE), .exe_o(exeM)
    );

    memResult uMem (
        .exe_i(exeM), .memRdata_i(memRdata_i), .hold_i(dStall_i),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o), .memWriteSel_o(memWriteSel_o),
        .memWdata_o(memWdata_o), .wb_o(wbM)
    );

    assign exeLoad = (decE.ctrl.memOp == mipsPkg::memLw) ||
                     (decE.ctrl.memOp == mipsPkg::memLb) ||
                     (decE.ctrl.memOp == mipsPkg::memLbu);

    hazardUnit uHazard (
        .exeLoad_i(exeLoad), .exeDest_i(decE.dest), .rsAddr_i(rsAddrD),
        .rtAddr_i(rtAddrD), .stallFD_o(stallFD), .bubbleE_o(bubbleE)
    );

    // debug port taken straight from M
    assign dbgPc_o      = exeM.pc;
    assign dbgRfWen_o   = {4{wbM.wen}};
    assign dbgRfWnum_o  = wbM.wnum;
    assign dbgRfWdata_o = wbM.wdata;

endmodule

// File: tb/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

    // one expected register write in program order
    typedef struct packed {
        mipsPkg::word_t    pc;
        mipsPkg::regAddr_t num;
        mipsPkg::word_t    data;
    } wbExp_s;

    localparam int progLen = 44;
    localparam int expLen  = 32;

    // program at address 0 with four words per line
    localparam mipsPkg::word_t progWords [progLen] = '{
        32'h2401_0005, 32'h2402_fffd, 32'h0022_1821, 32'h0061_2023,  // addiu addiu addu subu
        32'h0081_2824, 32'h00a2_3025, 32'h00c1_3826, 32'h00e1_402a,  // and or xor slt
        32'h0001_4900, 32'h0007_5702, 32'h30eb_ff00, 32'h340c_8001,  // sll srl andi ori
        32'h282d_ffff, 32'h3c0e_1234, 32'h35ce_5678, 32'hac0e_0010,  // slti lui ori sw
        32'h8c0f_0010, 32'h01e1_8021, 32'h2411_00a5, 32'ha011_0011,  // lw, use, addiu, sb
        32'h8c12_0010, 32'h8013_0011, 32'h9014_0011, 32'h8015_0013,  // lw lb lbu lb
        32'h02b3_b021, 32'h1025_0002, 32'h2417_0001, 32'h2418_07ff,  // use, beq taken, slot, skip
        32'h1421_0002, 32'h2418_0002, 32'h2419_0003, 32'h1423_0002,  // bne not taken, slot, bne
        32'h2739_0004, 32'h241a_0009, 32'h0c00_0028, 32'h241a_0005,  // slot, skip, jal, slot
        32'h275b_0001, 32'h0800_0025, 32'h0000_0000, 32'h0000_0000,  // return point, j self
        32'h241c_0010, 32'h03e0_0008, 32'h279d_0001, 32'h241e_0066   // callee, jr, slot, skip
    };

    // pc of the writer, register, value
    localparam wbExp_s expWb [expLen] = '{
        {32'h0000_0000, 5'd1,  32'h0000_0005}, {32'h0000_0004, 5'd2,  32'hffff_fffd},
        {32'h0000_0008, 5'd3,  32'h0000_0002}, {32'h0000_000c, 5'd4,  32'hffff_fffd},
        {32'h0000_0010, 5'd5,  32'h0000_0005}, {32'h0000_0014, 5'd6,  32'hffff_fffd},
        {32'h0000_0018, 5'd7,  32'hffff_fff8}, {32'h0000_001c, 5'd8,  32'h0000_0001},
        {32'h0000_0020, 5'd9,  32'h0000_0050}, {32'h0000_0024, 5'd10, 32'h0000_000f},
        {32'h0000_0028, 5'd11, 32'h0000_ff00}, {32'h0000_002c, 5'd12, 32'h0000_8001},
        {32'h0000_0030, 5'd13, 32'h0000_0000}, {32'h0000_0034, 5'd14, 32'h1234_0000},
        {32'h0000_0038, 5'd14, 32'h1234_5678}, {32'h0000_0040, 5'd15, 32'h1234_5678},
        {32'h0000_0044, 5'd16, 32'h1234_567d}, {32'h0000_0048, 5'd17, 32'h0000_00a5},
        {32'h0000_0050, 5'd18, 32'h1234_a578}, {32'h0000_0054, 5'd19, 32'hffff_ffa5},
        {32'h0000_0058, 5'd20, 32'h0000_00a5}, {32'h0000_005c, 5'd21, 32'h0000_0012},
        {32'h0000_0060, 5'd22, 32'hffff_ffb7}, {32'h0000_0068, 5'd23, 32'h0000_0001},
        {32'h0000_0074, 5'd24, 32'h0000_0002}, {32'h0000_0078, 5'd25, 32'h0000_0003},
        {32'h0000_0080, 5'd25, 32'h0000_0007}, {32'h0000_0088, 5'd31, 32'h0000_0090},
        {32'h0000_008c, 5'd26, 32'h0000_0005}, {32'h0000_00a0, 5'd28, 32'h0000_0010},
        {32'h0000_00a8, 5'd29, 32'h0000_0011}, {32'h0000_0090, 5'd27, 32'h0000_0006}
    };

`endif

// File: tb/tbMipsCore.sv
`timescale 1ns/10ps

module tbMipsCore;

    `include "tbProgram.svh"

    logic              clk;
    logic              rstN;
    logic              dStall;
    mipsPkg::word_t    instr;
    mipsPkg::word_t    memRdata;
    mipsPkg::word_t    instAddr;
    logic              instEn;
    logic              memEn;
    mipsPkg::word_t    memAddr;
    logic [3:0]        memWriteSel;
    mipsPkg::word_t    memWdata;
    mipsPkg::word_t    dbgPc;
    logic [3:0]        dbgRfWen;
    mipsPkg::regAddr_t dbgRfWnum;
    mipsPkg::word_t    dbgRfWdata;

    mipsPkg::word_t dataRam [256];
    int             wbIdx;  // next expected write
    int             cycles;
    logic [31:0]    lcgState;

    mipsCore #(.resetPc(32'h0)) dut (
        .clk(clk), .rstN_i(rstN), .instr_i(instr), .memRdata_i(memRdata),
        .dStall_i(dStall), .instAddr_o(instAddr), .instEn_o(instEn), .memEn_o(memEn),
        .memAddr_o(memAddr), .memWriteSel_o(memWriteSel), .memWdata_o(memWdata),
        .dbgPc_o(dbgPc), .dbgRfWen_o(dbgRfWen), .dbgRfWnum_o(dbgRfWnum),
        .dbgRfWdata_o(dbgRfWdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stopWithFail();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // combinational instruction ROM with nops past the program
    assign instr    = (instAddr[31:2] < progLen) ? progWords[instAddr[7:2]] : '0;
    assign memRdata = dataRam[memAddr[9:2]];

    // data RAM takes the write only when the port is not stalled
    always @(posedge clk) begin
        if (memEn && !dStall) begin
            for (int b = 0; b < 4; b++) begin
                if (memWriteSel[b]) begin
                    dataRam[memAddr[9:2]][8*b +: 8] <= memWdata[8*b +: 8];
                end
            end
        end
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            noWriteOnStall: assert (!(dStall && dbgRfWen != 4'b0)) else begin
                $display("register write seen while dStall is high at %0t", $time);
                stopWithFail();
            end
            if (dbgRfWen != 4'b0) begin
                noExtraWrite: assert (wbIdx < expLen) else begin
                    $display("unexpected register write r%0d at %0t", dbgRfWnum, $time);
                    stopWithFail();
                end
                wbMatch: assert (dbgPc == expWb[wbIdx].pc &&
                                 dbgRfWnum == expWb[wbIdx].num &&
                                 dbgRfWdata == expWb[wbIdx].data) else begin
                    $display("Mismatch at %0t: write %0d got pc %h r%0d = %h, %s %h r%0d = %h",
                             $time, wbIdx, dbgPc, dbgRfWnum, dbgRfWdata, "expected pc",
                             expWb[wbIdx].pc, expWb[wbIdx].num, expWb[wbIdx].data);
                    stopWithFail();
                end
                wbIdx++;
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        dStall   = 1'b0;
        wbIdx    = 0;
        cycles   = 0;
        lcgState = 32'h01b2_5732;
        for (int i = 0; i < 256; i++) begin
            dataRam[i] = 32'h5a00_0000 + i * 32'h0001_0103;
        end
        repeat (5) @(posedge clk);
        resetState: assert (instEn && !memEn && memWriteSel == 4'b0 && dbgRfWen == 4'b0 &&
                            instAddr == 32'h0) else begin
            $display("outputs not in their reset state at %0t", $time);
            stopWithFail();
        end
        #2 rstN = 1'b1;

        // about one cycle in five stalls the data port
        while (wbIdx < expLen && cycles < 2000) begin
            @(posedge clk);
            #2;
            lcgState = nextRandom(lcgState);
            dStall   = (lcgState[31:24] < 8'd51);
            cycles++;
        end

        if (wbIdx < expLen) begin
            $display("timeout after %0d cycles with %0d of %0d writes seen",
                     cycles, wbIdx, expLen);
            stopWithFail();
        end else begin
            // core sits in its self loop where no write is expected
            for (int n = 0; n < 20; n++) begin
                @(posedge clk);
                #2;
                lcgState = nextRandom(lcgState);
                dStall   = (lcgState[31:24] < 8'd51);
            end
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+tb
source/mipsPkg.sv
source/regFile.sv
source/instrDecode.sv
source/aluExecute.sv
source/memResult.sv
source/hazardUnit.sv
source/mipsCore.sv
tb/tbMipsCore.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - source/mipsPkg.sv
      - source/regFile.sv
      - source/instrDecode.sv
      - source/aluExecute.sv
      - source/memResult.sv
      - source/hazardUnit.sv
      - source/mipsCore.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbMipsCore.sv
